/* cmd_parser.sv */
`timescale 1ns/1ns

module cmd_parser import ctl_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 in_valid,
	input  logic [WORD_BITS-1:0] in_data,
	input  logic                 arg_advance,
	input  logic                 cmd_done,
	output opcode_t              cmd,
	output logic                 cmd_ready,
	output logic [WORD_BITS-1:0] arg_data,
	output logic [15:0]          drop_count
);

	parse_state_t         state;
	logic [7:0]           arg_total;  // Argument count from the header
	logic [7:0]           arg_cnt;    // Arguments received so far
	logic [WORD_BITS-1:0] args [MAX_ARGS];
	logic                 drop;

	assign arg_data = args[0];  // Head of the argument shift register

	// Anything outside the collect phase is lost, and so is an argument with no free slot
	always_comb begin
		drop = 1'b0;
		if (in_valid) begin
			case (state)
				P_HEADER: drop = 1'b0;
				P_ARGS:   drop = (arg_cnt >= MAX_ARGS);
				default:  drop = 1'b1;
			endcase
		end
	end

	// ==============================
	// Frame FSM
	// ==============================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= P_HEADER;
			cmd_ready  <= 1'b0;
			arg_total  <= '0;
			arg_cnt    <= '0;
			drop_count <= '0;
		end else begin
			cmd_ready <= 1'b0;
			if (drop)
				drop_count <= drop_count + 16'd1;
			case (state)
				P_HEADER: begin
					if (in_valid) begin
						arg_total <= in_data[15:8];
						arg_cnt   <= '0;
						state     <= (in_data[15:8] == 8'd0) ? P_ISSUE : P_ARGS;
					end
				end
				P_ARGS: begin
					if (in_valid) begin
						arg_cnt <= arg_cnt + 8'd1;
						if (arg_cnt == arg_total - 8'd1)
							state <= P_ISSUE;  // Last word of the frame
					end
				end
				P_ISSUE: begin
					cmd_ready <= 1'b1;  // Single cycle hand-off to the unit
					state     <= P_BUSY;
				end
				P_BUSY: begin
					if (cmd_done)
						state <= P_HEADER;
				end
				default: state <= P_HEADER;
			endcase
		end
	end

	// ==============================
	// Opcode and argument storage
	// ==============================

	always_ff @(posedge clk) begin
		if (state == P_HEADER && in_valid) begin
			cmd <= opcode_t'(in_data[OPCODE_BITS-1:0]);
			for (int i = 0; i < MAX_ARGS; i++)
				args[i] <= '0;  // Missing arguments read as zero
		end else if (state == P_ARGS && in_valid) begin
			for (int i = 0; i < MAX_ARGS; i++) begin
				if (arg_cnt == i)
					args[i] <= in_data;
			end
		end else if (arg_advance) begin
			for (int i = 0; i < MAX_ARGS - 1; i++)
				args[i] <= args[i + 1];  // Next argument moves to the head
			args[MAX_ARGS - 1] <= '0;
		end
	end

endmodule

/* ctl_pkg.sv */
package ctl_pkg;

	// ==============================
	// Widths and constants
	// ==============================

	localparam int OPCODE_BITS = 8;   // Opcode and response code share one byte
	localparam int WORD_BITS   = 32;  // Host word
	localparam int TIME_BITS   = 64;  // System time counter
	localparam int MAX_ARGS    = 2;   // Argument words kept per frame
	localparam int FW_VERSION  = 3;   // Build version reported to the host
	localparam int SYNC_COMP   = 4;   // Two sync stages, one capture, one load

	// ==============================
	// Encodings
	// ==============================

	typedef enum logic [OPCODE_BITS-1:0] {
		OP_GET_VERSION = 8'h01,
		OP_SYNC_TIME   = 8'h02,
		OP_GET_TIME    = 8'h03
	} opcode_t;

	typedef enum logic [OPCODE_BITS-1:0] {
		RSP_VERSION = 8'h81,
		RSP_TIME    = 8'h83,
		RSP_ERROR   = 8'hee  // No unit claims the opcode
	} rsp_code_t;

	// Command unit FSM
	typedef enum logic [1:0] {
		IDLE,
		SYNC_HI,
		TIME_HI,
		RSP_END
	} sys_state_t;

	// Frame parser FSM
	typedef enum logic [1:0] {
		P_HEADER,
		P_ARGS,
		P_ISSUE,
		P_BUSY
	} parse_state_t;

endpackage

/* ctl_top.sv */
`timescale 1ns/1ns

module ctl_top import ctl_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 in_valid,
	input  logic [WORD_BITS-1:0] in_data,
	input  logic                 sync_pulse_in,
	input  logic                 sync_arm_in,
	output logic                 rsp_valid,
	output logic [WORD_BITS-1:0] rsp_data,
	output logic                 rsp_last,
	output logic [15:0]          drop_count,
	output logic [TIME_BITS-1:0] sys_time
);

	// ==============================
	// Internal links
	// ==============================

	opcode_t              cmd;
	logic                 cmd_ready;
	logic [WORD_BITS-1:0] arg_data;
	logic                 arg_advance;
	logic                 cmd_done;
	logic [WORD_BITS-1:0] param_data;
	logic                 param_write;
	logic                 rsp_end;
	logic [TIME_BITS-1:0] time_new;
	logic                 time_load;

	cmd_parser u_parser (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.arg_advance (arg_advance),
		.cmd_done    (cmd_done),
		.cmd         (cmd),
		.cmd_ready   (cmd_ready),
		.arg_data    (arg_data),
		.drop_count  (drop_count)
	);

	sys_cmd_unit u_sys (
		.clk           (clk),
		.arst_n        (arst_n),
		.cmd           (cmd),
		.cmd_ready     (cmd_ready),
		.arg_data      (arg_data),
		.sys_time      (sys_time),
		.sync_pulse_in (sync_pulse_in),
		.sync_arm_in   (sync_arm_in),
		.arg_advance   (arg_advance),
		.cmd_done      (cmd_done),
		.param_data    (param_data),
		.param_write   (param_write),
		.rsp_end       (rsp_end),
		.time_new      (time_new),
		.time_load     (time_load)
	);

	time_base u_time (
		.clk       (clk),
		.arst_n    (arst_n),
		.time_new  (time_new),
		.time_load (time_load),
		.sys_time  (sys_time)
	);

	rsp_framer u_framer (
		.clk         (clk),
		.arst_n      (arst_n),
		.param_data  (param_data),
		.param_write (param_write),
		.rsp_end     (rsp_end),
		.rsp_valid   (rsp_valid),
		.rsp_data    (rsp_data),
		.rsp_last    (rsp_last)
	);

endmodule

/* rsp_framer.sv */
`timescale 1ns/1ns

module rsp_framer import ctl_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [WORD_BITS-1:0] param_data,
	input  logic                 param_write,
	input  logic                 rsp_end,
	output logic                 rsp_valid,
	output logic [WORD_BITS-1:0] rsp_data,
	output logic                 rsp_last
);

	logic [WORD_BITS-1:0] payload [2];
	logic [1:0]           wr_cnt;   // Payload words buffered for the next frame
	logic [1:0]           left;     // Payload words still to send
	logic                 rd_idx;
	logic                 buf_wr;
	rsp_code_t            rsp_code;

	assign rsp_code = rsp_code_t'(param_data[OPCODE_BITS-1:0]);
	assign buf_wr   = param_write && (wr_cnt != 2'd2);  // Extra words do not fit

	// ==============================
	// Output sequencing
	// ==============================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_cnt    <= '0;
			left      <= '0;
			rd_idx    <= 1'b0;
			rsp_valid <= 1'b0;
			rsp_last  <= 1'b0;
		end else begin
			if (rsp_end)
				wr_cnt <= '0;
			else if (buf_wr)
				wr_cnt <= wr_cnt + 2'd1;

			if (rsp_end) begin
				left      <= wr_cnt;
				rd_idx    <= 1'b0;
				rsp_valid <= 1'b1;             // Header goes out first
				rsp_last  <= (wr_cnt == 2'd0);
			end else if (left != 2'd0) begin
				left      <= left - 2'd1;
				rd_idx    <= ~rd_idx;
				rsp_valid <= 1'b1;
				rsp_last  <= (left == 2'd1);
			end else begin
				rsp_valid <= 1'b0;
				rsp_last  <= 1'b0;
			end
		end
	end

	// Header holds the code in bits 7:0 and the payload count in bits 15:8
	always_ff @(posedge clk) begin
		if (buf_wr)
			payload[wr_cnt[0]] <= param_data;
		if (rsp_end)
			rsp_data <= {16'd0, 8'(wr_cnt), rsp_code};
		else if (left != 2'd0)
			rsp_data <= payload[rd_idx];
	end

endmodule

/* sys_cmd_unit.sv */
`timescale 1ns/1ns

module sys_cmd_unit import ctl_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  opcode_t              cmd,
	input  logic                 cmd_ready,
	input  logic [WORD_BITS-1:0] arg_data,
	input  logic [TIME_BITS-1:0] sys_time,
	input  logic                 sync_pulse_in,
	input  logic                 sync_arm_in,
	output logic                 arg_advance,
	output logic                 cmd_done,
	output logic [WORD_BITS-1:0] param_data,
	output logic                 param_write,
	output logic                 rsp_end,
	output logic [TIME_BITS-1:0] time_new,
	output logic                 time_load
);

	logic                 pulse_meta;
	logic                 pulse_sync;
	logic                 pulse_prev;
	logic                 arm_meta;
	logic                 arm_sync;
	logic                 arm_prev;
	logic                 frozen;     // Timestamp held until the next sync command
	logic [TIME_BITS-1:0] stamp;      // System time at the last sync pulse
	sys_state_t           state;
	logic [WORD_BITS-1:0] hold_word;  // High time word or low offset word
	rsp_code_t            rsp_code;
	logic                 accept;

	assign accept      = (state == IDLE) && cmd_ready;
	assign arg_advance = accept;  // The first argument is consumed on acceptance

	// ==============================
	// Sync pulse and arm capture
	// ==============================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pulse_meta <= 1'b0;
			pulse_sync <= 1'b0;
			pulse_prev <= 1'b0;
			arm_meta   <= 1'b0;
			arm_sync   <= 1'b0;
			arm_prev   <= 1'b0;
			frozen     <= 1'b0;
		end else begin
			pulse_meta <= sync_pulse_in;
			pulse_sync <= pulse_meta;
			pulse_prev <= pulse_sync;
			arm_meta   <= sync_arm_in;
			arm_sync   <= arm_meta;
			arm_prev   <= arm_sync;
			if (state == SYNC_HI)
				frozen <= 1'b0;  // A finished sync re-opens the capture
			else if (arm_sync && !arm_prev)
				frozen <= 1'b1;
		end
	end

	// Both edges of the pulse mark a sync event
	always_ff @(posedge clk) begin
		if ((pulse_sync != pulse_prev) && !frozen)
			stamp <= sys_time;
	end

	// ==============================
	// Command FSM
	// ==============================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= IDLE;
			param_write <= 1'b0;
			rsp_end     <= 1'b0;
			cmd_done    <= 1'b0;
			time_load   <= 1'b0;
		end else begin
			param_write <= 1'b0;
			rsp_end     <= 1'b0;
			cmd_done    <= 1'b0;
			time_load   <= 1'b0;
			case (state)
				IDLE: begin
					if (cmd_ready) begin
						case (cmd)
							OP_GET_VERSION: begin
								param_write <= 1'b1;
								state       <= RSP_END;
							end
							OP_GET_TIME: begin
								param_write <= 1'b1;  // Low word first
								state       <= TIME_HI;
							end
							OP_SYNC_TIME: state <= SYNC_HI;
							default: begin
								rsp_end  <= 1'b1;  // Error frame with no payload
								cmd_done <= 1'b1;
							end
						endcase
					end
				end
				SYNC_HI: begin
					time_load <= 1'b1;  // Silent command, no response frame
					cmd_done  <= 1'b1;
					state     <= IDLE;
				end
				TIME_HI: begin
					param_write <= 1'b1;
					state       <= RSP_END;
				end
				RSP_END: begin
					rsp_end  <= 1'b1;
					cmd_done <= 1'b1;
					state    <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Data path follows the FSM state
	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (accept) begin
					case (cmd)
						OP_GET_VERSION: begin
							param_data <= WORD_BITS'(FW_VERSION);
							rsp_code   <= RSP_VERSION;
						end
						OP_GET_TIME: begin
							param_data <= sys_time[WORD_BITS-1:0];
							hold_word  <= sys_time[TIME_BITS-1:WORD_BITS];
							rsp_code   <= RSP_TIME;
						end
						OP_SYNC_TIME: hold_word <= arg_data;  // Low offset word
						default: param_data <= WORD_BITS'(RSP_ERROR);
					endcase
				end
			end
			// The extra count aligns with the time value present while time_load is high
			SYNC_HI: time_new <= sys_time + TIME_BITS'(1) - stamp + {arg_data, hold_word}
				+ TIME_BITS'(SYNC_COMP);
			TIME_HI: param_data <= hold_word;
			RSP_END: param_data <= WORD_BITS'(rsp_code);
			default: ;
		endcase
	end

endmodule

/* tb.f */
ctl_pkg.sv
cmd_parser.sv
sys_cmd_unit.sv
time_base.sv
rsp_framer.sv
ctl_top.sv
tb_ctl.sv

/* tb_ctl.sv */
`timescale 1ns/1ns

module tb_ctl import ctl_pkg::*; ();

	localparam int          CLK_PERIOD = 8;
	localparam int          NUM_TESTS  = 17;
	localparam int          TEST_BOUND = 200;  // Cycles allowed per test
	localparam logic [31:0] SEED       = 32'h2ee7_c48d;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	logic [31:0] in_data;
	logic        sync_pulse_in;
	logic        sync_arm_in;
	logic        rsp_valid;
	logic [31:0] rsp_data;
	logic        rsp_last;
	logic [15:0] drop_count;
	logic [63:0] sys_time;

	logic [31:0] lfsr;
	logic [31:0] rsp_q[$];         // Response words in arrival order
	logic        last_q[$];
	logic [63:0] mtime;            // Model of the system time
	longint      edge_no;          // Edges since reset release
	longint      load_at;
	logic        load_armed;
	logic [63:0] load_offset;
	logic [63:0] stamp_m;          // Model of the captured timestamp
	logic        frozen_m;
	int          drops_m;
	int          errors;
	int          errors_at_start;
	int          pass_count;
	int          fail_count;

	ctl_top dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==============================
	// Reference model and monitor
	// ==============================

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mtime   <= '0;
			edge_no <= 0;
		end else begin
			edge_no <= edge_no + 1;
			if (load_armed && edge_no == load_at) begin
				mtime      <= mtime - stamp_m + load_offset + 64'(SYNC_COMP);
				load_armed = 1'b0;
			end else begin
				mtime <= mtime + 64'd1;
			end
		end
	end

	// Outputs are sampled on the falling edge, away from the updates
	always @(negedge clk) begin
		if (arst_n && rsp_valid) begin
			rsp_q.push_back(rsp_data);
			last_q.push_back(rsp_last);
		end
		if (arst_n && sys_time !== mtime) begin
			$display("FAIL at %0t ns: sys_time is %h, expected %h", $time, sys_time, mtime);
			errors++;
		end
	end

	initial begin
		#(NUM_TESTS * TEST_BOUND * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * TEST_BOUND);
		$display("*** FAILED ***");
		$finish;
	end

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic logic [31:0] header_word(input logic [7:0] op, input logic [7:0] count);
		return {16'd0, count, op};
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Called 1 ns after an edge, the word is taken at the next edge
	task automatic send_word(input logic [31:0] w);
		in_valid = 1'b1;
		in_data  = w;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_data  = '0;
	endtask

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic expect_frame(input string name, input logic [7:0] code, input int n,
		input logic [63:0] payload);
		int          waited;
		logic [31:0] word;
		logic        last;
		logic [31:0] expected;
		waited = 0;
		while (rsp_q.size() < n + 1 && waited < 40) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (rsp_q.size() < n + 1) begin
			$display("Error at %0t ns: %s response did not arrive within 40 cycles", $time, name);
			errors++;
			return;
		end
		for (int i = 0; i <= n; i++) begin
			word     = rsp_q.pop_front();
			last     = last_q.pop_front();
			expected = (i == 0) ? header_word(code, 8'(n)) : payload[(i - 1) * 32 +: 32];
			check_value($sformatf("%s word %0d", name, i), word, expected);
			check_value($sformatf("%s rsp_last %0d", name, i), last, i == n);
		end
	endtask

	task automatic end_test(input string name);
		if (rsp_q.size() != 0) begin
			$display("Error at %0t ns: %0d unexpected response words in %s", $time, rsp_q.size(),
				name);
			errors++;
			rsp_q.delete();
			last_q.delete();
		end
		if (errors == errors_at_start) begin
			pass_count++;
			$display("test %0d %s: ok", pass_count + fail_count, name);
		end else begin
			fail_count++;
			$display("test %0d %s: %0d errors", pass_count + fail_count, name,
				errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// ==============================
	// Tests
	// ==============================

	task automatic get_time_check(input string name);
		logic [63:0] expected;
		send_word(header_word(OP_GET_TIME, 8'd0));
		expected = mtime + 64'd1;  // Time seen by the unit one edge later
		expect_frame(name, RSP_TIME, 2, expected);
	endtask

	task automatic test_sync(input logic armed);
		logic [63:0] offset;
		idle(rand_bits(4));
		sync_pulse_in = ~sync_pulse_in;
		if (!frozen_m)
			stamp_m = mtime + 64'd2;  // Two synchronizer stages before the capture edge
		idle(6);
		if (armed) begin
			sync_arm_in = 1'b1;
			frozen_m    = 1'b1;
		end
		idle(6);
		sync_pulse_in = ~sync_pulse_in;  // Moves the stamp only while the capture is open
		if (!frozen_m)
			stamp_m = mtime + 64'd2;
		idle(6);
		offset[31:0]  = rand_bits(32);
		offset[63:32] = rand_bits(32);
		send_word(header_word(OP_SYNC_TIME, 8'd2));
		send_word(offset[31:0]);
		send_word(offset[63:32]);
		load_offset = offset;
		load_at     = edge_no + 3;
		load_armed  = 1'b1;
		idle(6);
		frozen_m    = 1'b0;
		sync_arm_in = 1'b0;
		idle(4);
		get_time_check("sync_time");
		end_test(armed ? "sync_time_armed" : "sync_time");
	endtask

	task automatic test_unknown();
		logic [7:0] op;
		int         n;
		do
			op = rand_bits(8);
		while (op >= 8'd1 && op <= 8'd3);
		n = rand_bits(2) % 3;
		send_word(header_word(op, 8'(n)));
		repeat (n) send_word(rand_bits(32));
		expect_frame("unknown_opcode", RSP_ERROR, 0, 64'd0);
		end_test("unknown_opcode");
	endtask

	task automatic test_drop_busy();
		int          extra;
		logic [63:0] expected;
		extra = 1 + rand_bits(2);
		send_word(header_word(OP_GET_TIME, 8'd0));
		expected = mtime + 64'd1;
		repeat (extra) send_word(rand_bits(32));  // Parser is busy for all of these
		drops_m += extra;
		expect_frame("drop_busy", RSP_TIME, 2, expected);
		check_value("drop_count", drop_count, 64'(drops_m));
		end_test("drop_busy");
	endtask

	task automatic test_drop_args();
		int n;
		n = 3 + rand_bits(1);
		send_word(header_word(OP_GET_VERSION, 8'(n)));
		repeat (n) send_word(rand_bits(32));
		drops_m += n - MAX_ARGS;
		expect_frame("drop_args", RSP_VERSION, 1, 64'(FW_VERSION));
		check_value("drop_count", drop_count, 64'(drops_m));
		end_test("drop_args");
	endtask

	initial begin
		clk             = 1'b0;
		arst_n          = 1'b0;
		in_valid        = 1'b0;
		in_data         = '0;
		sync_pulse_in   = 1'b0;
		sync_arm_in     = 1'b0;
		lfsr            = SEED;
		load_armed      = 1'b0;
		load_at         = 0;
		load_offset     = '0;
		stamp_m         = '0;
		frozen_m        = 1'b0;
		drops_m         = 0;
		errors          = 0;
		errors_at_start = 0;
		pass_count      = 0;
		fail_count      = 0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;

		check_value("rsp_valid after reset", rsp_valid, 64'd0);
		check_value("drop_count after reset", drop_count, 64'd0);
		send_word(header_word(OP_GET_VERSION, 8'd0));
		expect_frame("get_version", RSP_VERSION, 1, 64'(FW_VERSION));
		end_test("get_version");

		repeat (6) begin
			idle(rand_bits(4));
			get_time_check("get_time");
			end_test("get_time");
		end
		repeat (4) test_unknown();
		test_sync(1'b0);
		test_sync(1'b1);
		repeat (2) test_sync(rand_bits(1) == 32'd1);
		test_drop_busy();
		test_drop_args();

		$display("tests %0d, passed %0d, failed %0d, errors %0d", pass_count + fail_count,
			pass_count, fail_count, errors);
		if (fail_count == 0 && errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* time_base.sv */
`timescale 1ns/1ns

module time_base import ctl_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [TIME_BITS-1:0] time_new,
	input  logic                 time_load,
	output logic [TIME_BITS-1:0] sys_time
);

	// Free-running system time, one count per clock
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sys_time <= '0;
		end else if (time_load) begin
			sys_time <= time_new;  // Corrected value from a sync command
		end else begin
			sys_time <= sys_time + TIME_BITS'(1);
		end
	end

endmodule
